// ==== source/capture_pkg.sv ====
package capture_pkg;

    // frame geometry
    localparam int NUM_CH    = 4;
    localparam int BUF_DEPTH = 256;             // samples per frame and per buffer
    localparam int FRAME_LEN = 2 * BUF_DEPTH;   // capture half + readout half

    localparam int SAMPLE_W = 8;
    localparam int ADDR_W   = $clog2(BUF_DEPTH);
    localparam int CNT_W    = $clog2(FRAME_LEN);

    typedef logic [SAMPLE_W-1:0] sample_t;  // unsigned sample
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [CNT_W-1:0]    frame_cnt_t;

    // write request, same for every channel
    typedef struct packed {
        logic  en;
        addr_t addr;
    } ram_wr_t;

    // read request, same for every channel
    typedef struct packed {
        logic  en;
        addr_t addr;
    } ram_rd_t;

    // one playback beat
    typedef struct packed {
        logic    valid;
        sample_t sample;
    } play_t;

    // largest sample of a frame and where it sits in the buffer
    typedef struct packed {
        sample_t value;
        addr_t   addr;
    } peak_t;

endpackage

// ==== source/sample_ram.sv ====
`timescale 1ns/100ps

module sample_ram
(
    input  logic                 sys_clk,
    input  capture_pkg::ram_wr_t wr,
    input  capture_pkg::sample_t wr_data,
    input  capture_pkg::ram_rd_t rd,
    output capture_pkg::sample_t rd_data
);

    // inferred simple dual-port storage
    capture_pkg::sample_t mem [capture_pkg::BUF_DEPTH];

    // write port
    always_ff @(posedge sys_clk)
    begin
        if (wr.en)
        begin
            mem[wr.addr] <= wr_data;
        end
    end

    // registered read port, data one cycle after the request
    always_ff @(posedge sys_clk)
    begin
        if (rd.en)
        begin
            rd_data <= mem[rd.addr];    // holds its value while rd.en is low
        end
    end

endmodule

// ==== source/frame_sequencer.sv ====
`timescale 1ns/100ps

module frame_sequencer
(
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    output capture_pkg::ram_wr_t wr_req,
    output capture_pkg::ram_rd_t rd_req,
    output logic                 capture_window
);

    localparam capture_pkg::frame_cnt_t CNT_LAST =
        capture_pkg::frame_cnt_t'(capture_pkg::FRAME_LEN - 1);
    localparam capture_pkg::frame_cnt_t CNT_HALF =
        capture_pkg::frame_cnt_t'(capture_pkg::BUF_DEPTH);

    capture_pkg::frame_cnt_t frame_cnt;
    capture_pkg::frame_cnt_t rev_cnt;
    logic                    seq_run;   // low until the first edge after reset
    logic                    lower_half;

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            seq_run <= 1'b0;
        end
        else
        begin
            seq_run <= 1'b1;
        end
    end

    // free-running frame counter, 0 to FRAME_LEN-1
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            frame_cnt <= '0;
        end
        else if (seq_run)
        begin
            if (frame_cnt == CNT_LAST)
                frame_cnt <= '0;
            else
                frame_cnt <= frame_cnt + 1'b1;
        end
    end

    assign lower_half = (frame_cnt < CNT_HALF);
    assign rev_cnt    = CNT_LAST - frame_cnt;   // 255 down to 0 in the upper half

    always_comb
    begin
        capture_window = seq_run & lower_half;
        wr_req.en      = seq_run & lower_half;
        wr_req.addr    = frame_cnt[capture_pkg::ADDR_W-1:0];
        rd_req.en      = seq_run & ~lower_half;
        rd_req.addr    = rev_cnt[capture_pkg::ADDR_W-1:0];    // truncated to the address width
    end

endmodule

// ==== source/peak_finder.sv ====
`timescale 1ns/100ps

module peak_finder
(
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  capture_pkg::ram_rd_t rd,
    input  capture_pkg::sample_t rd_data,
    output capture_pkg::play_t   play,
    output capture_pkg::peak_t   peak,
    output logic                 peak_valid
);

    localparam capture_pkg::addr_t ADDR_FIRST =
        capture_pkg::addr_t'(capture_pkg::BUF_DEPTH - 1);   // scan starts at the top
    localparam capture_pkg::addr_t ADDR_FINAL = '0;

    capture_pkg::ram_rd_t rd_q;     // request delayed to meet rd_data
    capture_pkg::peak_t   run_max;
    capture_pkg::peak_t   next_max;
    logic                 take_new;
    logic                 scan_done;

    // read latency latch
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            rd_q <= '0;
        end
        else
        begin
            rd_q <= rd;
        end
    end

    assign play.valid  = rd_q.en;
    assign play.sample = rd_data;

    // restart on the first beat, otherwise >= so ties move to the lower address
    assign take_new  = (rd_q.addr == ADDR_FIRST) || (rd_data >= run_max.value);
    assign scan_done = rd_q.en && (rd_q.addr == ADDR_FINAL);

    always_comb
    begin
        next_max = run_max;
        if (take_new)
        begin
            next_max.value = rd_data;
            next_max.addr  = rd_q.addr;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            run_max <= '0;
        end
        else if (rd_q.en)
        begin
            run_max <= next_max;
        end
    end

    // result lands one cycle after the last beat
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            peak       <= '0;
            peak_valid <= 1'b0;
        end
        else
        begin
            peak_valid <= scan_done;
            if (scan_done)
                peak <= next_max;   // includes the address 0 sample
        end
    end

endmodule

// ==== source/capture_channel.sv ====
`timescale 1ns/100ps

module capture_channel
(
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  capture_pkg::ram_wr_t wr,
    input  capture_pkg::ram_rd_t rd,
    input  capture_pkg::sample_t sample,
    output capture_pkg::play_t   play,
    output capture_pkg::peak_t   peak,
    output logic                 peak_valid
);

    capture_pkg::sample_t rd_data;  // buffer output, one cycle behind rd

    // per-channel buffer, written in order during the capture window
    sample_ram u_ram
    (
        .sys_clk (sys_clk),
        .wr      (wr),
        .wr_data (sample),
        .rd      (rd),
        .rd_data (rd_data)
    );

    // reverse-order scan of the same buffer
    peak_finder u_peak
    (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .rd         (rd),
        .rd_data    (rd_data),
        .play       (play),
        .peak       (peak),
        .peak_valid (peak_valid)
    );

endmodule

// ==== source/peak_capture_top.sv ====
`timescale 1ns/100ps

module peak_capture_top
(
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  capture_pkg::sample_t samples    [capture_pkg::NUM_CH],
    output logic                 capture_window,
    output capture_pkg::play_t   play       [capture_pkg::NUM_CH],
    output capture_pkg::peak_t   peak       [capture_pkg::NUM_CH],
    output logic                 peak_valid [capture_pkg::NUM_CH]
);

    // shared requests, fanned out to every channel
    capture_pkg::ram_wr_t wr_req;
    capture_pkg::ram_rd_t rd_req;

    frame_sequencer u_seq
    (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .wr_req         (wr_req),
        .rd_req         (rd_req),
        .capture_window (capture_window)
    );

    // one buffer and scanner per channel
    for (genvar i = 0; i < capture_pkg::NUM_CH; i++)
    begin : g_ch
        capture_channel u_ch
        (
            .sys_clk    (sys_clk),
            .sys_rst_n  (sys_rst_n),
            .wr         (wr_req),
            .rd         (rd_req),
            .sample     (samples[i]),
            .play       (play[i]),
            .peak       (peak[i]),
            .peak_valid (peak_valid[i])
        );
    end

endmodule

// ==== tb/tb_peak_capture.sv ====
`timescale 1ns/100ps

module tb_peak_capture;

    logic sys_clk = 1'b0;
    logic sys_rst_n;

    capture_pkg::sample_t samples    [capture_pkg::NUM_CH];
    logic                 capture_window;
    capture_pkg::play_t   play       [capture_pkg::NUM_CH];
    capture_pkg::peak_t   peak       [capture_pkg::NUM_CH];
    logic                 peak_valid [capture_pkg::NUM_CH];

    // reference model state
    capture_pkg::sample_t cap_win [capture_pkg::NUM_CH][capture_pkg::BUF_DEPTH];
    capture_pkg::sample_t ref_win [capture_pkg::NUM_CH][capture_pkg::BUF_DEPTH];
    capture_pkg::sample_t exp_max  [capture_pkg::NUM_CH];
    capture_pkg::addr_t   exp_addr [capture_pkg::NUM_CH];
    int beat   [capture_pkg::NUM_CH];   // playback beats seen in the current run
    int pulses [capture_pkg::NUM_CH];
    int wcnt    = 0;                    // next write address of the window
    int win_idx = 0;                    // completed windows
    int cyc     = 0;
    int err_val = 0;
    int err_seq = 0;
    int err_to  = 0;
    logic [31:0] lcg_state = 32'd99;

    always #5 sys_clk = ~sys_clk;

    peak_capture_top u_dut
    (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .samples        (samples),
        .capture_window (capture_window),
        .play           (play),
        .peak           (peak),
        .peak_valid     (peak_valid)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] exp_v,
                                   input logic [15:0] got_v);
        $display("ERR %s exp %0h got %0h", name, exp_v, got_v);
        err_val++;
    endtask

    task automatic flag_sequence_fault(input string what);
        $display("%s", what);
        err_seq++;
    endtask

    // model capture, window copy and sample drive
    always @(posedge sys_clk)
    begin
        cyc = cyc + 1;
        if (capture_window)
        begin
            for (int c = 0; c < capture_pkg::NUM_CH; c++)
                cap_win[c][wcnt] = samples[c];  // value the DUT writes at this edge
            wcnt = wcnt + 1;
        end
        else if (wcnt != 0)
        begin
            ref_win = cap_win;
            for (int c = 0; c < capture_pkg::NUM_CH; c++)
            begin
                exp_max[c]  = ref_win[c][0];
                exp_addr[c] = '0;
                for (int a = 1; a < capture_pkg::BUF_DEPTH; a++)
                begin
                    if (ref_win[c][a] > exp_max[c])    // strict compare keeps the lowest address
                    begin
                        exp_max[c]  = ref_win[c][a];
                        exp_addr[c] = capture_pkg::addr_t'(a);
                    end
                end
            end
            wcnt    = 0;
            win_idx = win_idx + 1;
        end
        for (int c = 0; c < capture_pkg::NUM_CH; c++)
        begin
            beat[c] = play[c].valid ? beat[c] + 1 : 0;
            if (peak_valid[c])
                pulses[c] = pulses[c] + 1;
            lcg_state = lcg_next(lcg_state);
            if (win_idx % 3 == 2)   // tie frame of a constant plus twin maxima on one channel
                samples[c] <= ((c == win_idx % capture_pkg::NUM_CH) && (wcnt == 37 || wcnt == 200))
                              ? 8'hc0 : 8'h20;
            else
                samples[c] <= lcg_state[23:16];
        end
    end

    // capture window length
    assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $fell(capture_window) |-> wcnt == capture_pkg::BUF_DEPTH)
        else flag_sequence_fault($sformatf("capture window length was %0d cycles",
            $sampled(wcnt)));
    assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        capture_window |-> wcnt < capture_pkg::BUF_DEPTH)
        else flag_sequence_fault("capture window ran past 256 cycles");

    for (genvar c = 0; c < capture_pkg::NUM_CH; c++)
    begin : g_chk
        // idle during reset and on the first edge after it
        assert property (@(posedge sys_clk) (cyc > 0) && (!sys_rst_n || $rose(sys_rst_n))
            |-> !capture_window && !play[c].valid && !peak_valid[c])
            else flag_sequence_fault($sformatf("channel %0d not idle around reset", c));
        assert property (@(posedge sys_clk) (cyc > 0) && (!sys_rst_n || $rose(sys_rst_n))
            |-> peak[c] == '0)
            else report_mismatch($sformatf("peak[%0d]", c), 16'h0, $sampled(peak[c]));

        // reverse playback
        assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
            play[c].valid |-> play[c].sample == ref_win[c][capture_pkg::BUF_DEPTH - 1 - beat[c]])
            else report_mismatch($sformatf("play[%0d].sample", c),
                $sampled(ref_win[c][capture_pkg::BUF_DEPTH - 1 - beat[c]]),
                $sampled(play[c].sample));
        assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
            $fell(play[c].valid) |-> beat[c] == capture_pkg::BUF_DEPTH)
            else flag_sequence_fault($sformatf("channel %0d playback run was %0d beats",
                c, $sampled(beat[c])));

        // peak result at the pulse
        assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
            peak_valid[c] |-> peak[c].value == exp_max[c])
            else report_mismatch($sformatf("peak[%0d].value", c), $sampled(exp_max[c]),
                $sampled(peak[c].value));
        assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
            peak_valid[c] |-> peak[c].addr == exp_addr[c])
            else report_mismatch($sformatf("peak[%0d].addr", c), $sampled(exp_addr[c]),
                $sampled(peak[c].addr));

        // pulse follows the last beat and never overlaps playback
        assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
            $fell(play[c].valid) |-> peak_valid[c])
            else flag_sequence_fault($sformatf("channel %0d missed the pulse after playback",
                c));
        assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
            peak_valid[c] |-> !play[c].valid && $past(play[c].valid))
            else flag_sequence_fault($sformatf("channel %0d pulse out of place", c));
    end

    task automatic wait_play_start(input int f);
        int n;
        n = 0;
        while (!play[0].valid && n < 2 * capture_pkg::FRAME_LEN)
        begin
            @(negedge sys_clk);
            n++;
        end
        if (!play[0].valid)
        begin
            $display("timeout waiting for playback start of frame %0d", f);
            err_to++;
        end
    endtask

    task automatic wait_peak_pulse(input int f);
        int n;
        n = 0;
        while (!peak_valid[0] && n < 2 * capture_pkg::FRAME_LEN)
        begin
            @(negedge sys_clk);
            n++;
        end
        if (!peak_valid[0])
        begin
            $display("timeout waiting for peak_valid of frame %0d", f);
            err_to++;
        end
    endtask

    initial
    begin
        sys_rst_n = 1'b0;
        for (int c = 0; c < capture_pkg::NUM_CH; c++)
        begin
            samples[c] = '0;
            beat[c]    = 0;
            pulses[c]  = 0;
        end
        repeat (16) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        for (int f = 0; f < 6; f++)     // six frames
        begin
            wait_play_start(f);
            wait_peak_pulse(f);
        end
        repeat (4) @(negedge sys_clk);
        for (int c = 0; c < capture_pkg::NUM_CH; c++)
        begin
            if (pulses[c] != 6)
            begin
                $display("channel %0d gave %0d peak pulses instead of 6", c, pulses[c]);
                err_seq++;
            end
        end
        $display("errors: %0d value, %0d sequence, %0d timeout", err_val, err_seq, err_to);
        if (err_val + err_seq + err_to == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
source/capture_pkg.sv
source/sample_ram.sv
source/frame_sequencer.sv
source/peak_finder.sv
source/capture_channel.sv
source/peak_capture_top.sv
tb/tb_peak_capture.sv

// ==== Bender.yml ====
package:
  name: peak_capture

dependencies: {}

sources:
  # package first, then leaf modules up to the top level
  - files:
      - source/capture_pkg.sv
      - source/sample_ram.sv
      - source/frame_sequencer.sv
      - source/peak_finder.sv
      - source/capture_channel.sv
      - source/peak_capture_top.sv

  # testbench
  - target: test
    files:
      - tb/tb_peak_capture.sv
